// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := cpu_tb
FILE_LIST := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/cpu_alu.sv
`default_nettype none

module cpu_alu (
    input  wire  cpu_pkg::opcode_t  opcode,
    input  wire  cpu_pkg::word_t    operand_a,
    input  wire  cpu_pkg::word_t    operand_b,
    input  wire                     flag_a,
    input  wire  cpu_pkg::imm_t     imm,
    input  wire  cpu_pkg::word_t    load_data,
    output cpu_pkg::word_t          result,
    output logic                    flag_out,
    output cpu_pkg::addr_t          mem_address,
    output logic                    branch_taken
);

    cpu_pkg::word_t imm_ext;
    logic           less_than;

    assign imm_ext   = cpu_pkg::word_t'(imm);
    assign less_than = operand_a < operand_b;

    always_comb
    begin
        case (opcode)
            cpu_pkg::OP_ADD:
                result = operand_a + operand_b;
            cpu_pkg::OP_SUB:
                result = operand_a - operand_b;
            cpu_pkg::OP_AND:
                result = operand_a & operand_b;
            cpu_pkg::OP_OR:
                result = operand_a | operand_b;
            cpu_pkg::OP_XOR:
                result = operand_a ^ operand_b;
            // shift amount is the low five bits of B
            cpu_pkg::OP_SHL:
                result = operand_a << operand_b[4:0];
            cpu_pkg::OP_SHR:
                result = operand_a >> operand_b[4:0];
            cpu_pkg::OP_LOADI:
                result = imm_ext;
            cpu_pkg::OP_CMPLT:
                result = cpu_pkg::word_t'(less_than);
            cpu_pkg::OP_LOAD:
                result = load_data;
            default:
                result = '0;
        endcase
    end

    // CMPLT flags the comparison, everything else flags a zero result
    always_comb
    begin
        if (opcode == cpu_pkg::OP_CMPLT)
        begin
            flag_out = less_than;
        end
        else
        begin
            flag_out = (result == '0);
        end
    end

    // effective address for LOAD and STORE
    assign mem_address = operand_b + imm_ext;

    always_comb
    begin
        case (opcode)
            cpu_pkg::OP_BRF:
                branch_taken = flag_a;
            cpu_pkg::OP_JMP:
                branch_taken = 1'b1;
            default:
                branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/cpu_control.sv
`default_nettype none

`include "cpu_params.svh"

module cpu_control (
    input  wire                      clock,
    input  wire                      reset,
    input  wire  cpu_pkg::word_t     data,
    input  wire  cpu_pkg::addr_t     pc,
    input  wire  cpu_pkg::addr_t     mem_address,
    output cpu_pkg::opcode_t         opcode,
    output cpu_pkg::reg_sel_t        src_a,
    output cpu_pkg::reg_sel_t        src_b,
    output cpu_pkg::reg_sel_t        dst,
    output cpu_pkg::imm_t            imm,
    output logic                     reg_write,
    output logic                     pc_update,
    output cpu_pkg::addr_t           address,
    output logic                     rw,
    output logic                     halted
);

    cpu_pkg::cpu_state_t state;
    cpu_pkg::cpu_state_t next_state;
    cpu_pkg::word_t      instr;
    logic                writes_result;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= cpu_pkg::FETCH;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        case (state)
            cpu_pkg::FETCH:
                next_state = cpu_pkg::EXECUTE;
            cpu_pkg::EXECUTE:
                next_state = (opcode == cpu_pkg::OP_HALT) ? cpu_pkg::HALTED : cpu_pkg::ADVANCE;
            cpu_pkg::ADVANCE:
                next_state = cpu_pkg::FETCH;
            default:
                next_state = cpu_pkg::HALTED;
        endcase
    end

    // instruction latched at the end of FETCH, held through ADVANCE
    always_ff @(posedge clock)
    begin
        if (state == cpu_pkg::FETCH)
        begin
            instr <= data;
        end
    end

    // field decode
    assign opcode = cpu_pkg::opcode_t'(instr[`CPU_OPCODE_WIDTH-1:0]);
    assign dst    = instr[`CPU_DST_LSB +: `CPU_SEL_WIDTH];
    assign src_a  = instr[`CPU_SRCA_LSB +: `CPU_SEL_WIDTH];
    assign src_b  = instr[`CPU_SRCB_LSB +: `CPU_SEL_WIDTH];
    assign imm    = instr[`CPU_IMM_LSB +: `CPU_IMM_WIDTH];

    always_comb
    begin
        case (opcode)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
            cpu_pkg::OP_XOR, cpu_pkg::OP_SHL, cpu_pkg::OP_SHR, cpu_pkg::OP_LOADI,
            cpu_pkg::OP_CMPLT, cpu_pkg::OP_LOAD:
                writes_result = 1'b1;
            default:
                writes_result = 1'b0;
        endcase
    end

    assign reg_write = (state == cpu_pkg::EXECUTE) && writes_result;
    assign pc_update = (state == cpu_pkg::ADVANCE);
    assign halted    = (state == cpu_pkg::HALTED);

    // memory port: data access in EXECUTE, instruction address otherwise
    assign address = (state == cpu_pkg::EXECUTE) ? mem_address : pc;
    assign rw      = !((state == cpu_pkg::EXECUTE) && (opcode == cpu_pkg::OP_STORE));

endmodule

`default_nettype wire

// File: hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and address width
`define CPU_WORD_WIDTH   32
`define CPU_NUM_REGS     8
`define CPU_SEL_WIDTH    3
`define CPU_OPCODE_WIDTH 7
`define CPU_IMM_WIDTH    16

// instruction field positions
`define CPU_DST_LSB      7
`define CPU_SRCA_LSB     10
`define CPU_SRCB_LSB     13
`define CPU_IMM_LSB      16

`endif

// File: hw/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [`CPU_WORD_WIDTH-1:0] addr_t;
    typedef logic [`CPU_SEL_WIDTH-1:0]  reg_sel_t;
    typedef logic [`CPU_IMM_WIDTH-1:0]  imm_t;

    // opcode 0 and unlisted codes decode as no-operation
    typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
        OP_ADD   = 7'h01,
        OP_SUB   = 7'h02,
        OP_AND   = 7'h03,
        OP_OR    = 7'h04,
        OP_XOR   = 7'h05,
        OP_SHL   = 7'h06,
        OP_STORE = 7'h07,
        OP_SHR   = 7'h08,
        OP_LOADI = 7'h09,
        OP_CMPLT = 7'h0a,
        OP_LOAD  = 7'h0b,
        OP_BRF   = 7'h0c,
        OP_JMP   = 7'h0d,
        OP_HALT  = 7'h0e
    } opcode_t;

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        ADVANCE = 2'd2,
        HALTED  = 2'd3
    } cpu_state_t;

endpackage

`default_nettype wire

// File: hw/cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire                   clock,
    input  wire                   reset,
    input  wire  cpu_pkg::word_t  data,
    output wire  cpu_pkg::word_t  datao,
    output wire  cpu_pkg::addr_t  address,
    output wire                   rw,
    output wire                   halted
);

    wire cpu_pkg::opcode_t  opcode;
    wire cpu_pkg::reg_sel_t src_a;
    wire cpu_pkg::reg_sel_t src_b;
    wire cpu_pkg::reg_sel_t dst;
    wire cpu_pkg::imm_t     imm;
    wire                    reg_write;
    wire                    pc_update;
    wire cpu_pkg::word_t    read_data_a;
    wire cpu_pkg::word_t    read_data_b;
    wire                    read_flag_a;
    wire cpu_pkg::word_t    result;
    wire                    flag_out;
    wire cpu_pkg::addr_t    mem_address;
    wire                    branch_taken;
    wire cpu_pkg::addr_t    pc;

    cpu_control u_control (
        .clock       (clock),
        .reset       (reset),
        .data        (data),
        .pc          (pc),
        .mem_address (mem_address),
        .opcode      (opcode),
        .src_a       (src_a),
        .src_b       (src_b),
        .dst         (dst),
        .imm         (imm),
        .reg_write   (reg_write),
        .pc_update   (pc_update),
        .address     (address),
        .rw          (rw),
        .halted      (halted)
    );

    register_file u_regs (
        .clock        (clock),
        .reset        (reset),
        .read_sel_a   (src_a),
        .read_sel_b   (src_b),
        .write_sel    (dst),
        .write_enable (reg_write),
        .write_data   (result),
        .write_flag   (flag_out),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b),
        .read_flag_a  (read_flag_a)
    );

    cpu_alu u_alu (
        .opcode       (opcode),
        .operand_a    (read_data_a),
        .operand_b    (read_data_b),
        .flag_a       (read_flag_a),
        .imm          (imm),
        .load_data    (data),
        .result       (result),
        .flag_out     (flag_out),
        .mem_address  (mem_address),
        .branch_taken (branch_taken)
    );

    program_counter u_pc (
        .clock        (clock),
        .reset        (reset),
        .update       (pc_update),
        .branch_taken (branch_taken),
        .target       (imm),
        .pc           (pc)
    );

    // store data is always register A
    assign datao = read_data_a;

endmodule

`default_nettype wire

// File: hw/program_counter.sv
`default_nettype none

module program_counter (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  update,
    input  wire                  branch_taken,
    input  wire  cpu_pkg::imm_t  target,
    output cpu_pkg::addr_t       pc
);

    cpu_pkg::addr_t next_pc;

    // branch targets are absolute word addresses
    always_comb
    begin
        if (branch_taken)
        begin
            next_pc = cpu_pkg::addr_t'(target);
        end
        else
        begin
            next_pc = pc + 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else if (update)
        begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/register_file.sv
`default_nettype none

`include "cpu_params.svh"

module register_file (
    input  wire                      clock,
    input  wire                      reset,
    input  wire  cpu_pkg::reg_sel_t  read_sel_a,
    input  wire  cpu_pkg::reg_sel_t  read_sel_b,
    input  wire  cpu_pkg::reg_sel_t  write_sel,
    input  wire                      write_enable,
    input  wire  cpu_pkg::word_t     write_data,
    input  wire                      write_flag,
    output cpu_pkg::word_t           read_data_a,
    output cpu_pkg::word_t           read_data_b,
    output logic                     read_flag_a
);

    cpu_pkg::word_t           regs [`CPU_NUM_REGS];
    logic [`CPU_NUM_REGS-1:0] flags;

    // word and flag always move together
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (write_enable)
        begin
            regs[write_sel]  <= write_data;
            flags[write_sel] <= write_flag;
        end
    end

    // combinational read ports
    assign read_data_a = regs[read_sel_a];
    assign read_data_b = regs[read_sel_b];

    // only port A needs its flag, for BRF
    assign read_flag_a = flags[read_sel_a];

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/cpu_pkg.sv
hw/register_file.sv
hw/cpu_alu.sv
hw/program_counter.sv
hw/cpu_control.sv
hw/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

// File: verif/cpu_sva.sv
`default_nettype none

module cpu_sva (
    input wire                      clock,
    input wire                      reset,
    input wire cpu_pkg::cpu_state_t state,
    input wire                      rw,
    input wire                      halted
);

    // the bus only writes in the cycle right after an instruction fetch
    assert property (@(posedge clock) disable iff (reset)
        !rw |-> (state == cpu_pkg::EXECUTE) && ($past(state) == cpu_pkg::FETCH))
        else $error("rw low outside EXECUTE");

    assert property (@(posedge clock) disable iff (reset)
        (state == cpu_pkg::FETCH) |=> (state == cpu_pkg::EXECUTE))
        else $error("FETCH not followed by EXECUTE");

    assert property (@(posedge clock) disable iff (reset)
        (state == cpu_pkg::EXECUTE) |=>
        (state == cpu_pkg::ADVANCE || state == cpu_pkg::HALTED))
        else $error("EXECUTE not followed by ADVANCE or HALTED");

    assert property (@(posedge clock) disable iff (reset)
        (state == cpu_pkg::ADVANCE) |=> (state == cpu_pkg::FETCH))
        else $error("ADVANCE not followed by FETCH");

    // only reset leaves HALTED
    assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped without reset");

endmodule

bind cpu_control cpu_sva u_sva (
    .clock  (clock),
    .reset  (reset),
    .state  (state),
    .rw     (rw),
    .halted (halted)
);

`default_nettype wire

// File: verif/cpu_tb.sv
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;

    logic           clock;
    logic           reset;
    cpu_pkg::word_t data;
    cpu_pkg::word_t datao;
    cpu_pkg::addr_t address;
    logic           rw;
    logic           halted;

    cpu_pkg::word_t mem [256];
    cpu_pkg::word_t image [256];

    // ISA model state
    cpu_pkg::word_t           ref_mem [256];
    cpu_pkg::word_t           ref_regs [`CPU_NUM_REGS];
    logic [`CPU_NUM_REGS-1:0] ref_flags;
    cpu_pkg::addr_t           ref_pc;
    logic                     ref_halted;
    logic                     exp_store;
    cpu_pkg::addr_t           exp_store_addr;
    cpu_pkg::word_t           exp_store_data;

    string       test_name;
    int          phase;
    int          prog_addr;
    logic [31:0] rng_state;

    cpu_top u_dut (
        .clock   (clock),
        .reset   (reset),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw),
        .halted  (halted)
    );

    always #2 clock = ~clock;

    assign data = mem[address[7:0]];

    // the program image is copied in while reset is held
    always @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < 256; i++)
            begin
                mem[i] <= image[i];
            end
        end
        else if (rw == 1'b0)
        begin
            mem[address[7:0]] <= datao;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string what, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        if (act !== exp)
        begin
            $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string what, input cpu_pkg::addr_t exp,
                              input cpu_pkg::addr_t act);
        if (act !== exp)
        begin
            $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR %s %s expected %b actual %b", test_name, what, exp, act);
            stop_run();
        end
    endtask

    // one instruction of the ISA, applied to the model state
    function automatic void model_step();
        cpu_pkg::word_t    instr;
        cpu_pkg::word_t    a;
        cpu_pkg::word_t    b;
        cpu_pkg::word_t    res;
        cpu_pkg::addr_t    ea;
        cpu_pkg::addr_t    next_pc;
        cpu_pkg::imm_t     im;
        cpu_pkg::reg_sel_t d;
        cpu_pkg::reg_sel_t sa;
        logic [6:0]        op;
        logic              writes;
        instr     = ref_mem[ref_pc[7:0]];
        op        = instr[`CPU_OPCODE_WIDTH-1:0];
        d         = instr[`CPU_DST_LSB +: `CPU_SEL_WIDTH];
        sa        = instr[`CPU_SRCA_LSB +: `CPU_SEL_WIDTH];
        a         = ref_regs[sa];
        b         = ref_regs[instr[`CPU_SRCB_LSB +: `CPU_SEL_WIDTH]];
        im        = instr[`CPU_IMM_LSB +: `CPU_IMM_WIDTH];
        ea        = b + {16'h0, im};
        res       = '0;
        writes    = 1'b1;
        exp_store = 1'b0;
        next_pc   = ref_pc + 32'd1;
        case (op)
            cpu_pkg::OP_ADD:   res = a + b;
            cpu_pkg::OP_SUB:   res = a - b;
            cpu_pkg::OP_AND:   res = a & b;
            cpu_pkg::OP_OR:    res = a | b;
            cpu_pkg::OP_XOR:   res = a ^ b;
            cpu_pkg::OP_SHL:   res = a << b[4:0];
            cpu_pkg::OP_SHR:   res = a >> b[4:0];
            cpu_pkg::OP_LOADI: res = {16'h0, im};
            cpu_pkg::OP_CMPLT: res = (a < b) ? 32'd1 : 32'd0;
            cpu_pkg::OP_LOAD:  res = ref_mem[ea[7:0]];
            cpu_pkg::OP_STORE:
            begin
                writes          = 1'b0;
                exp_store       = 1'b1;
                exp_store_addr  = ea;
                exp_store_data  = a;
                ref_mem[ea[7:0]] = a;
            end
            cpu_pkg::OP_BRF:
            begin
                writes = 1'b0;
                if (ref_flags[sa])
                begin
                    next_pc = {16'h0, im};
                end
            end
            cpu_pkg::OP_JMP:
            begin
                writes  = 1'b0;
                next_pc = {16'h0, im};
            end
            cpu_pkg::OP_HALT:
            begin
                writes     = 1'b0;
                ref_halted = 1'b1;
                next_pc    = ref_pc;
            end
            default: writes = 1'b0;
        endcase
        if (writes)
        begin
            ref_regs[d]  = res;
            ref_flags[d] = (op == cpu_pkg::OP_CMPLT) ? (a < b) : (res == '0);
        end
        ref_pc = next_pc;
    endfunction

    // phase 0 ends a FETCH, 1 an EXECUTE, 2 an ADVANCE, 3 is HALTED
    always @(posedge clock)
    begin
        if (reset)
        begin
            phase      = 0;
            ref_pc     = '0;
            ref_halted = 1'b0;
            exp_store  = 1'b0;
            ref_flags  = '0;
            for (int i = 0; i < 256; i++)
            begin
                ref_mem[i] = image[i];
            end
            for (int r = 0; r < `CPU_NUM_REGS; r++)
            begin
                ref_regs[r] = '0;
            end
        end
        else
        begin
            case (phase)
                0:
                begin
                    check_addr("fetch address", ref_pc, address);
                    check_bit("fetch rw", 1'b1, rw);
                    check_bit("halted during fetch", 1'b0, halted);
                    model_step();
                    phase = 1;
                end
                1:
                begin
                    if (exp_store)
                    begin
                        check_bit("store rw", 1'b0, rw);
                        check_addr("store address", exp_store_addr, address);
                        check_word("store data", exp_store_data, datao);
                    end
                    else
                    begin
                        check_bit("execute rw", 1'b1, rw);
                    end
                    phase = ref_halted ? 3 : 2;
                end
                2:
                begin
                    check_bit("advance rw", 1'b1, rw);
                    phase = 0;
                end
                default:
                begin
                    check_bit("halted", 1'b1, halted);
                    check_bit("halted rw", 1'b1, rw);
                    check_addr("halted address", ref_pc, address);
                end
            endcase
        end
    end

    function automatic cpu_pkg::word_t encode(input logic [6:0] op, input int d, input int a,
                                              input int b, input int im);
        cpu_pkg::word_t w;
        w = '0;
        w[`CPU_OPCODE_WIDTH-1:0]           = op;
        w[`CPU_DST_LSB +: `CPU_SEL_WIDTH]  = cpu_pkg::reg_sel_t'(d);
        w[`CPU_SRCA_LSB +: `CPU_SEL_WIDTH] = cpu_pkg::reg_sel_t'(a);
        w[`CPU_SRCB_LSB +: `CPU_SEL_WIDTH] = cpu_pkg::reg_sel_t'(b);
        w[`CPU_IMM_LSB +: `CPU_IMM_WIDTH]  = cpu_pkg::imm_t'(im);
        return w;
    endfunction

    task automatic emit(input logic [6:0] op, input int d, input int a, input int b,
                        input int im);
        image[prog_addr] = encode(op, d, a, b, im);
        prog_addr++;
    endtask

    // full 32-bit random value into a register, r7 is scratch
    task automatic load_random(input int r);
        logic [31:0] v;
        v = next_random();
        emit(cpu_pkg::OP_LOADI, r, 0, 0, int'(v[31:16]));
        emit(cpu_pkg::OP_LOADI, 7, 0, 0, 16);
        emit(cpu_pkg::OP_SHL, r, r, 7, 0);
        emit(cpu_pkg::OP_LOADI, 7, 0, 0, int'(v[15:0]));
        emit(cpu_pkg::OP_OR, r, r, 7, 0);
    endtask

    task automatic begin_test(input string name);
        @(negedge clock);
        reset     = 1'b1;
        test_name = name;
        prog_addr = 0;
        for (int i = 0; i < 256; i++)
        begin
            image[i] = 32'hc0de0000 | i;
        end
    endtask

    task automatic run_test(input int limit);
        int n;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        check_addr("first fetch address", '0, address);
        check_bit("first fetch rw", 1'b1, rw);
        check_bit("halted after reset", 1'b0, halted);
        n = 0;
        while (halted !== 1'b1 && n < limit)
        begin
            @(negedge clock);
            n++;
        end
        if (halted !== 1'b1)
        begin
            $display("Test %s did not halt within %0d cycles", test_name, limit);
            stop_run();
        end
        repeat (3) @(negedge clock);
    endtask

    task automatic test_alu_ops();
        cpu_pkg::opcode_t ops [7];
        ops = '{cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                cpu_pkg::OP_XOR, cpu_pkg::OP_SHL, cpu_pkg::OP_SHR};
        begin_test("alu_ops");
        for (int k = 0; k < 7; k++)
        begin
            load_random(1);
            load_random(2);
            emit(ops[k], 3, 1, 2, 0);
            emit(cpu_pkg::OP_STORE, 0, 3, 0, 128 + k);
        end
        emit(cpu_pkg::OP_HALT, 0, 0, 0, 0);
        run_test(400);
    endtask

    task automatic test_load_store();
        begin_test("load_store");
        for (int k = 0; k < 5; k++)
        begin
            image[200 + k] = next_random();
        end
        emit(cpu_pkg::OP_LOADI, 6, 0, 0, 100);
        for (int k = 0; k < 5; k++)
        begin
            emit(cpu_pkg::OP_LOAD, k + 1, 0, 6, 100 + k);
        end
        for (int k = 0; k < 5; k++)
        begin
            emit(cpu_pkg::OP_STORE, 0, k + 1, 6, 140 + k);
        end
        emit(cpu_pkg::OP_HALT, 0, 0, 0, 0);
        run_test(100);
    endtask

    // each BRF skips a STORE when taken, so both paths rejoin
    task automatic test_branches();
        logic [31:0] v;
        begin_test("branches");
        for (int k = 0; k < 4; k++)
        begin
            v = next_random();
            emit(cpu_pkg::OP_LOADI, 1, 0, 0, int'(v[31:16]));
            emit(cpu_pkg::OP_LOADI, 2, 0, 0, int'(v[15:0]));
            emit(cpu_pkg::OP_CMPLT, 3, 1, 2, 0);
            emit(cpu_pkg::OP_BRF, 0, 3, 0, prog_addr + 2);
            emit(cpu_pkg::OP_STORE, 0, 1, 0, 160 + k);
            emit(cpu_pkg::OP_SUB, 4, 1, 1, 0);
            emit(cpu_pkg::OP_BRF, 0, 4, 0, prog_addr + 2);
            emit(cpu_pkg::OP_STORE, 0, 2, 0, 170 + k);
            emit(cpu_pkg::OP_SUB, 5, 1, 2, 0);
            emit(cpu_pkg::OP_BRF, 0, 5, 0, prog_addr + 2);
            emit(cpu_pkg::OP_STORE, 0, 5, 0, 180 + k);
        end
        emit(cpu_pkg::OP_JMP, 0, 0, 0, prog_addr + 2);
        emit(cpu_pkg::OP_STORE, 0, 1, 0, 190);
        emit(cpu_pkg::OP_HALT, 0, 0, 0, 0);
        run_test(200);
    endtask

    // r0 stays zero as the LOAD and STORE base, branches only go forward
    task automatic test_random_program();
        cpu_pkg::opcode_t ops [13];
        logic [31:0]      r;
        logic [6:0]       op;
        int               b;
        int               im;
        ops = '{cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                cpu_pkg::OP_XOR, cpu_pkg::OP_SHL, cpu_pkg::OP_SHR, cpu_pkg::OP_LOADI,
                cpu_pkg::OP_CMPLT, cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE, cpu_pkg::OP_BRF,
                cpu_pkg::OP_JMP};
        begin_test("random_program");
        for (int i = 0; i < 40; i++)
        begin
            r  = next_random();
            op = (r[3:0] > 4'd12) ? 7'h7f : ops[r[3:0]];
            b  = int'(r[12:10]);
            im = int'(r[31:16]);
            if (op == cpu_pkg::OP_LOAD || op == cpu_pkg::OP_STORE)
            begin
                b  = 0;
                im = 128 + im % 128;
            end
            else if (op == cpu_pkg::OP_BRF || op == cpu_pkg::OP_JMP)
            begin
                im = (i + 1 + im % 4 > 40) ? 40 : i + 1 + im % 4;
            end
            emit(op, 1 + int'(r[6:4]) % 7, int'(r[9:7]), b, im);
        end
        emit(cpu_pkg::OP_HALT, 0, 0, 0, 0);
        run_test(200);
    endtask

    initial
    begin
        clock     = 1'b0;
        reset     = 1'b1;
        rng_state = 32'hfce6;
        begin_test("reset_halt");
        emit(cpu_pkg::OP_HALT, 0, 0, 0, 0);
        run_test(20);
        test_alu_ops();
        test_load_store();
        test_branches();
        test_random_program();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
